//--- Bender.yml
package:
  name: id_stage

sources:
  - decode_pkg.sv
  - inst_decoder.sv
  - id_regfile.sv
  - operand_bypass.sv
  - branch_unit.sv
  - id_stage.sv
  - target: simulation
    files:
      - id_checker.sv
      - tb_id_stage.sv

//--- all.f
decode_pkg.sv
inst_decoder.sv
id_regfile.sv
operand_bypass.sv
branch_unit.sv
id_stage.sv
id_checker.sv
tb_id_stage.sv

//--- branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
  input  decode_pkg::br_kind_t        br_kind,
  input  logic [decode_pkg::xlen-1:0] pc,
  input  logic [decode_pkg::xlen-1:0] imm,
  input  logic [decode_pkg::xlen-1:0] rj_value,
  input  logic [decode_pkg::xlen-1:0] rkd_value,
  input  logic                        leaving,
  output decode_pkg::br_bus_t         br_bus
);
  import decode_pkg::*;

  logic eq;
  logic lt_s;
  logic lt_u;
  logic cond;

  assign eq   = rj_value == rkd_value;
  assign lt_u = rj_value < rkd_value;
  assign lt_s = $signed(rj_value) < $signed(rkd_value);

  always_comb begin
    case (br_kind)
      br_beq:               cond = eq;
      br_bne:               cond = !eq;
      br_blt:               cond = lt_s;
      br_bge:               cond = !lt_s;
      br_bltu:              cond = lt_u;
      br_bgeu:              cond = !lt_u;
      br_jirl, br_b, br_bl: cond = 1'b1;
      default:              cond = 1'b0;
    endcase
  end

  // only redirect fetch once the branch actually moves on
  always_comb begin
    br_bus.taken  = cond && leaving;
    br_bus.target = ((br_kind == br_jirl) ? rj_value : pc) + imm;
  end

endmodule

`default_nettype wire

//--- decode_pkg.sv
`default_nettype none

package decode_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int nregs      = 32;

  // 3r opcodes, inst[31:15]
  localparam logic [16:0] op_add_w  = 17'h00020;
  localparam logic [16:0] op_sub_w  = 17'h00022;
  localparam logic [16:0] op_slt    = 17'h00024;
  localparam logic [16:0] op_sltu   = 17'h00025;
  localparam logic [16:0] op_nor    = 17'h00028;
  localparam logic [16:0] op_and    = 17'h00029;
  localparam logic [16:0] op_or     = 17'h0002a;
  localparam logic [16:0] op_xor    = 17'h0002b;
  localparam logic [16:0] op_sll_w  = 17'h0002e;
  localparam logic [16:0] op_srl_w  = 17'h0002f;
  localparam logic [16:0] op_sra_w  = 17'h00030;
  localparam logic [16:0] op_slli_w = 17'h00081;
  localparam logic [16:0] op_srli_w = 17'h00089;
  localparam logic [16:0] op_srai_w = 17'h00091;

  // 2ri12 opcodes, inst[31:22]
  localparam logic [9:0] op_slti   = 10'h008;
  localparam logic [9:0] op_sltui  = 10'h009;
  localparam logic [9:0] op_addi_w = 10'h00a;
  localparam logic [9:0] op_andi   = 10'h00d;
  localparam logic [9:0] op_ori    = 10'h00e;
  localparam logic [9:0] op_xori   = 10'h00f;

  // 1ri20 opcodes, inst[31:25]
  localparam logic [6:0] op_lu12i_w   = 7'h0a;
  localparam logic [6:0] op_pcaddu12i = 7'h0e;

  // branch opcodes, inst[31:26]
  localparam logic [5:0] op_jirl = 6'h13;
  localparam logic [5:0] op_b    = 6'h14;
  localparam logic [5:0] op_bl   = 6'h15;
  localparam logic [5:0] op_beq  = 6'h16;
  localparam logic [5:0] op_bne  = 6'h17;
  localparam logic [5:0] op_blt  = 6'h18;
  localparam logic [5:0] op_bge  = 6'h19;
  localparam logic [5:0] op_bltu = 6'h1a;
  localparam logic [5:0] op_bgeu = 6'h1b;

  // one-hot alu_op bit positions
  localparam int alu_add  = 0;
  localparam int alu_sub  = 1;
  localparam int alu_slt  = 2;
  localparam int alu_sltu = 3;
  localparam int alu_and  = 4;
  localparam int alu_nor  = 5;
  localparam int alu_or   = 6;
  localparam int alu_xor  = 7;
  localparam int alu_sll  = 8;
  localparam int alu_srl  = 9;
  localparam int alu_sra  = 10;
  localparam int alu_lui  = 11;

  typedef logic [11:0] alu_op_t;

  typedef enum logic [3:0] {
    br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_jirl, br_b, br_bl
  } br_kind_t;

  typedef union packed {
    struct packed {
      logic [16:0]           op;
      logic [reg_addr_w-1:0] rk;
      logic [reg_addr_w-1:0] rj;
      logic [reg_addr_w-1:0] rd;
    } fmt_3r;
    struct packed {
      logic [9:0]            op;
      logic [11:0]           i12;
      logic [reg_addr_w-1:0] rj;
      logic [reg_addr_w-1:0] rd;
    } fmt_2ri12;
    struct packed {
      logic [5:0]            op;
      logic [15:0]           i16;
      logic [reg_addr_w-1:0] rj;
      logic [reg_addr_w-1:0] rd;
    } fmt_2ri16;
    struct packed {
      logic [6:0]            op;
      logic [19:0]           i20;
      logic [reg_addr_w-1:0] rd;
    } fmt_1ri20;
    struct packed {
      logic [5:0]  op;
      logic [15:0] i26_lo;
      logic [9:0]  i26_hi;
    } fmt_i26;
  } inst_u;

  typedef struct packed {
    logic [xlen-1:0] pc;
    inst_u           inst;
  } fs_to_ds_t;

  typedef struct packed {
    alu_op_t               alu_op;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    logic                  src2_is_4;
    logic                  gr_we;
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       rj_value;
    logic [xlen-1:0]       rkd_value;
    logic [xlen-1:0]       pc;
  } ds_to_es_t;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic                  valid;
    logic                  not_ready;
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       data;
  } fwd_t;

  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
  } wb_t;

endpackage

`default_nettype wire

//--- id_checker.sv
`timescale 1ns/10ps
`default_nettype none

module id_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fs_valid,
  input  decode_pkg::fs_to_ds_t fs_bus,
  input  logic                  ds_allowin,
  input  logic                  ds_to_es_valid,
  input  decode_pkg::ds_to_es_t ds_to_es_bus,
  input  logic                  es_allowin,
  input  decode_pkg::br_bus_t   br_bus,
  input  decode_pkg::fwd_t      es_fwd,
  input  decode_pkg::fwd_t      ms_fwd,
  input  decode_pkg::wb_t       ws,
  output int                    error_count,
  output int                    check_count
);
  import decode_pkg::*;

  typedef struct packed {
    ds_to_es_t       bus;
    logic            cond;
    logic [xlen-1:0] target;
    logic            stall;
  } ref_t;

  logic [xlen-1:0] shadow [nregs];
  logic            mvalid;
  fs_to_ds_t       mbus;
  logic            held;
  ds_to_es_t       held_bus;
  int              accepted;
  int              flushed;
  int              left_cnt;

  initial begin
    error_count = 0;
    check_count = 0;
  end

  task automatic compare_value(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // {stall, value} of one source, youngest producer first
  function automatic logic [xlen:0] operand(input logic [4:0] a, input logic use_it,
                                            input fwd_t es, input fwd_t ms, input wb_t w);
    if (a == 5'd0) return '0;
    if (use_it && es.valid && es.dest == a) return {es.not_ready, es.data};
    if (use_it && ms.valid && ms.dest == a) return {ms.not_ready, ms.data};
    if (use_it && w.we && w.waddr == a) return {1'b0, w.wdata};
    return {1'b0, shadow[a]};
  endfunction

  function automatic logic [84:0] held_fields(input ds_to_es_t b);
    return {b.alu_op, b.src1_is_pc, b.src2_is_imm, b.src2_is_4, b.gr_we, b.dest, b.imm, b.pc};
  endfunction

  function automatic ref_t model_stage(input fs_to_ds_t fb, input fwd_t es, input fwd_t ms,
                                       input wb_t w);
    ref_t          r;
    logic [31:0]   i;
    logic          is3r, issh, is12s, is12u, is20, condbr, isjirl, isb, isbl, ispcadd;
    logic          use_rj, use_rk;
    logic [4:0]    src2;
    logic [xlen:0] o1, o2;
    int            idx;
    i = fb.inst;
    r = '0;
    idx = -1;
    is3r = i[31:15] inside {op_add_w, op_sub_w, op_slt, op_sltu, op_nor, op_and, op_or,
                            op_xor, op_sll_w, op_srl_w, op_sra_w};
    issh    = i[31:15] inside {op_slli_w, op_srli_w, op_srai_w};
    is12s   = i[31:22] inside {op_addi_w, op_slti, op_sltui};
    is12u   = i[31:22] inside {op_andi, op_ori, op_xori};
    is20    = i[31:25] inside {op_lu12i_w, op_pcaddu12i};
    ispcadd = i[31:25] == op_pcaddu12i;
    condbr  = i[31:26] inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    isjirl  = i[31:26] == op_jirl;
    isb     = i[31:26] == op_b;
    isbl    = i[31:26] == op_bl;

    case (i[31:15])
      op_add_w:             idx = alu_add;
      op_sub_w:             idx = alu_sub;
      op_slt:               idx = alu_slt;
      op_sltu:              idx = alu_sltu;
      op_and:               idx = alu_and;
      op_nor:               idx = alu_nor;
      op_or:                idx = alu_or;
      op_xor:               idx = alu_xor;
      op_sll_w, op_slli_w:  idx = alu_sll;
      op_srl_w, op_srli_w:  idx = alu_srl;
      op_sra_w, op_srai_w:  idx = alu_sra;
      default: ;
    endcase
    case (i[31:22])
      op_addi_w: idx = alu_add;
      op_slti:   idx = alu_slt;
      op_sltui:  idx = alu_sltu;
      op_andi:   idx = alu_and;
      op_ori:    idx = alu_or;
      op_xori:   idx = alu_xor;
      default: ;
    endcase
    // link value and pc-relative add both go through the adder
    if (isjirl || isbl || ispcadd) idx = alu_add;
    if (i[31:25] == op_lu12i_w) idx = alu_lui;
    if (idx >= 0) r.bus.alu_op[idx] = 1'b1;

    if (issh) r.bus.imm = {27'b0, i[14:10]};
    else if (is12s) r.bus.imm = {{20{i[21]}}, i[21:10]};
    else if (is12u) r.bus.imm = {20'b0, i[21:10]};
    else if (condbr || isjirl) r.bus.imm = {{14{i[25]}}, i[25:10], 2'b0};
    else if (is20) r.bus.imm = {i[24:5], 12'b0};
    else if (isb || isbl) r.bus.imm = {{4{i[9]}}, i[9:0], i[25:10], 2'b0};

    r.bus.src1_is_pc  = isjirl || isbl || ispcadd;
    r.bus.src2_is_imm = issh || is12s || is12u || is20;
    r.bus.src2_is_4   = isjirl || isbl;
    r.bus.gr_we       = !(condbr || isb);
    r.bus.dest        = isbl ? 5'd1 : i[4:0];
    r.bus.pc          = fb.pc;

    use_rj = is3r || issh || is12s || is12u || condbr || isjirl;
    use_rk = is3r || condbr;
    src2   = condbr ? i[4:0] : i[14:10];
    o1 = operand(i[9:5], use_rj, es, ms, w);
    o2 = operand(src2, use_rk, es, ms, w);
    r.bus.rj_value  = o1[xlen-1:0];
    r.bus.rkd_value = o2[xlen-1:0];
    r.stall = o1[xlen] || o2[xlen];

    case (i[31:26])
      op_beq:               r.cond = o1[xlen-1:0] == o2[xlen-1:0];
      op_bne:               r.cond = o1[xlen-1:0] != o2[xlen-1:0];
      op_blt:               r.cond = $signed(o1[xlen-1:0]) < $signed(o2[xlen-1:0]);
      op_bge:               r.cond = $signed(o1[xlen-1:0]) >= $signed(o2[xlen-1:0]);
      op_bltu:              r.cond = o1[xlen-1:0] < o2[xlen-1:0];
      op_bgeu:              r.cond = o1[xlen-1:0] >= o2[xlen-1:0];
      op_jirl, op_b, op_bl: r.cond = 1'b1;
      default:              r.cond = 1'b0;
    endcase
    r.target = (isjirl ? o1[xlen-1:0] : fb.pc) + r.bus.imm;
    return r;
  endfunction

  always @(posedge clk) begin : sample
    ref_t r;
    logic exp_valid, exp_leave, exp_allow, exp_taken, xfer;
    if (!rst_n) begin
      mvalid = 1'b0;
      held = 1'b0;
      accepted = 0;
      flushed = 0;
      left_cnt = 0;
    end else begin
      r = model_stage(mbus, es_fwd, ms_fwd, ws);
      exp_valid = mvalid && !r.stall;
      exp_leave = exp_valid && es_allowin;
      exp_allow = !mvalid || exp_leave;
      exp_taken = exp_leave && r.cond;
      compare_value("ds_to_es_valid", ds_to_es_valid, exp_valid);
      compare_value("ds_allowin", ds_allowin, exp_allow);
      compare_value("br_bus.taken", br_bus.taken, exp_taken);
      if (mvalid) compare_value("ds_to_es_bus", ds_to_es_bus, r.bus);
      if (exp_taken) compare_value("br_bus.target", br_bus.target, r.target);
      // back-pressure keeps control and pc steady
      if (held && mvalid) begin
        compare_value("ds_to_es_bus held fields", held_fields(ds_to_es_bus),
                      held_fields(held_bus));
      end

      xfer = fs_valid && ds_allowin;
      if (xfer) accepted++;
      if (xfer && br_bus.taken) flushed++;
      if (ds_to_es_valid && es_allowin) left_cnt++;

      held = mvalid && !exp_leave;
      held_bus = ds_to_es_bus;
      if (exp_taken) begin
        mvalid = 1'b0;
      end else if (exp_allow) begin
        mvalid = fs_valid;
        if (fs_valid) mbus = fs_bus;
      end
      if (ws.we && ws.waddr != 5'd0) shadow[ws.waddr] = ws.wdata;

      if (accepted - flushed - left_cnt != int'(mvalid)) begin
        error_count++;
        $display("instruction count mismatch at %0t: accepted %0d flushed %0d left %0d",
                 $time, accepted, flushed, left_cnt);
      end
    end
  end

endmodule

`default_nettype wire

//--- id_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module id_regfile (
  input  logic                              clk,
  input  logic [decode_pkg::reg_addr_w-1:0] raddr1,
  input  logic [decode_pkg::reg_addr_w-1:0] raddr2,
  output logic [decode_pkg::xlen-1:0]       rdata1,
  output logic [decode_pkg::xlen-1:0]       rdata2,
  input  decode_pkg::wb_t                   wb
);
  import decode_pkg::*;

  logic [xlen-1:0] regs [nregs];

  // r0 is hardwired, never written
  always_ff @(posedge clk) begin
    if (wb.we && wb.waddr != '0) begin
      regs[wb.waddr] <= wb.wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fs_valid,
  input  decode_pkg::fs_to_ds_t fs_bus,
  output logic                  ds_allowin,
  output logic                  ds_to_es_valid,
  output decode_pkg::ds_to_es_t ds_to_es_bus,
  input  logic                  es_allowin,
  output decode_pkg::br_bus_t   br_bus,
  input  decode_pkg::fwd_t      es_fwd,
  input  decode_pkg::fwd_t      ms_fwd,
  input  decode_pkg::wb_t       ws
);
  import decode_pkg::*;

  logic                  ds_valid;
  fs_to_ds_t             ds_bus;
  logic                  leaving;
  logic                  stall;
  alu_op_t               alu_op;
  br_kind_t              br_kind;
  logic                  src1_is_pc, src2_is_imm, src2_is_4, gr_we;
  logic                  need_rj, need_rkd;
  logic [reg_addr_w-1:0] dest, raddr1, raddr2;
  logic [xlen-1:0]       imm, rdata1, rdata2, rj_value, rkd_value;
  logic                  es_block, ms_block;

  assign ds_to_es_valid = ds_valid && !stall;
  assign leaving        = ds_to_es_valid && es_allowin;
  assign ds_allowin     = !ds_valid || leaving;

  // taken branch squashes whatever fetch offers this cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ds_valid <= 1'b0;
    end else if (br_bus.taken) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= fs_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fs_valid && ds_allowin && !br_bus.taken) begin
      ds_bus <= fs_bus;
    end
  end

  inst_decoder i_decoder (
    .inst        (ds_bus.inst),
    .alu_op      (alu_op),
    .br_kind     (br_kind),
    .src1_is_pc  (src1_is_pc),
    .src2_is_imm (src2_is_imm),
    .src2_is_4   (src2_is_4),
    .gr_we       (gr_we),
    .need_rj     (need_rj),
    .need_rkd    (need_rkd),
    .dest        (dest),
    .raddr1      (raddr1),
    .raddr2      (raddr2),
    .imm         (imm)
  );

  id_regfile i_regfile (
    .clk    (clk),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wb     (ws)
  );

  operand_bypass i_bypass (
    .raddr1    (raddr1),
    .raddr2    (raddr2),
    .need_rj   (need_rj),
    .need_rkd  (need_rkd),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .es_fwd    (es_fwd),
    .ms_fwd    (ms_fwd),
    .wb        (ws),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .stall     (stall)
  );

  branch_unit i_branch (
    .br_kind   (br_kind),
    .pc        (ds_bus.pc),
    .imm       (imm),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .leaving   (leaving),
    .br_bus    (br_bus)
  );

  assign ds_to_es_bus = '{
    alu_op:      alu_op,
    src1_is_pc:  src1_is_pc,
    src2_is_imm: src2_is_imm,
    src2_is_4:   src2_is_4,
    gr_we:       gr_we,
    dest:        dest,
    imm:         imm,
    rj_value:    rj_value,
    rkd_value:   rkd_value,
    pc:          ds_bus.pc
  };

  // used source waiting on a late producer
  assign es_block = es_fwd.valid && es_fwd.not_ready && es_fwd.dest != '0 &&
                    ((need_rj && es_fwd.dest == raddr1) || (need_rkd && es_fwd.dest == raddr2));
  assign ms_block = ms_fwd.valid && ms_fwd.not_ready && ms_fwd.dest != '0 &&
                    ((need_rj && ms_fwd.dest == raddr1) || (need_rkd && ms_fwd.dest == raddr2));

  a_stall_cause: assert property (@(posedge clk) disable iff (!rst_n)
    stall |-> es_block || ms_block);

  // stalled instruction is held in place, not offered
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ds_valid && stall |-> !ds_to_es_valid ##1 ds_valid && $stable(ds_to_es_bus.pc));

  a_taken_leaves: assert property (@(posedge clk) disable iff (!rst_n)
    br_bus.taken |-> leaving ##1 !ds_valid);

endmodule

`default_nettype wire

//--- inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
  input  decode_pkg::inst_u                 inst,
  output decode_pkg::alu_op_t               alu_op,
  output decode_pkg::br_kind_t              br_kind,
  output logic                              src1_is_pc,
  output logic                              src2_is_imm,
  output logic                              src2_is_4,
  output logic                              gr_we,
  output logic                              need_rj,
  output logic                              need_rkd,
  output logic [decode_pkg::reg_addr_w-1:0] dest,
  output logic [decode_pkg::reg_addr_w-1:0] raddr1,
  output logic [decode_pkg::reg_addr_w-1:0] raddr2,
  output logic [decode_pkg::xlen-1:0]       imm
);
  import decode_pkg::*;

  logic is_add, is_sub, is_slt, is_sltu, is_and, is_or, is_nor, is_xor;
  logic is_sll, is_srl, is_sra, is_slli, is_srli, is_srai;
  logic is_addi, is_slti, is_sltui, is_andi, is_ori, is_xori;
  logic is_lu12i, is_pcaddu12i;
  logic is_jirl, is_b, is_bl, is_cond_br;
  logic reg_3r;
  logic need_ui5, need_si12, need_ui12, need_si16, need_i20, need_si26;

  assign is_add  = inst.fmt_3r.op == op_add_w;
  assign is_sub  = inst.fmt_3r.op == op_sub_w;
  assign is_slt  = inst.fmt_3r.op == op_slt;
  assign is_sltu = inst.fmt_3r.op == op_sltu;
  assign is_and  = inst.fmt_3r.op == op_and;
  assign is_or   = inst.fmt_3r.op == op_or;
  assign is_nor  = inst.fmt_3r.op == op_nor;
  assign is_xor  = inst.fmt_3r.op == op_xor;
  assign is_sll  = inst.fmt_3r.op == op_sll_w;
  assign is_srl  = inst.fmt_3r.op == op_srl_w;
  assign is_sra  = inst.fmt_3r.op == op_sra_w;
  assign is_slli = inst.fmt_3r.op == op_slli_w;
  assign is_srli = inst.fmt_3r.op == op_srli_w;
  assign is_srai = inst.fmt_3r.op == op_srai_w;

  assign is_addi  = inst.fmt_2ri12.op == op_addi_w;
  assign is_slti  = inst.fmt_2ri12.op == op_slti;
  assign is_sltui = inst.fmt_2ri12.op == op_sltui;
  assign is_andi  = inst.fmt_2ri12.op == op_andi;
  assign is_ori   = inst.fmt_2ri12.op == op_ori;
  assign is_xori  = inst.fmt_2ri12.op == op_xori;

  assign is_lu12i     = inst.fmt_1ri20.op == op_lu12i_w;
  assign is_pcaddu12i = inst.fmt_1ri20.op == op_pcaddu12i;

  always_comb begin
    case (inst.fmt_2ri16.op)
      op_beq:  br_kind = br_beq;
      op_bne:  br_kind = br_bne;
      op_blt:  br_kind = br_blt;
      op_bge:  br_kind = br_bge;
      op_bltu: br_kind = br_bltu;
      op_bgeu: br_kind = br_bgeu;
      op_jirl: br_kind = br_jirl;
      op_b:    br_kind = br_b;
      op_bl:   br_kind = br_bl;
      default: br_kind = br_none;
    endcase
  end

  assign is_jirl    = br_kind == br_jirl;
  assign is_b       = br_kind == br_b;
  assign is_bl      = br_kind == br_bl;
  assign is_cond_br = br_kind inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};

  // jirl and bl compute pc + 4 as link value
  assign alu_op[alu_add]  = is_add | is_addi | is_jirl | is_bl | is_pcaddu12i;
  assign alu_op[alu_sub]  = is_sub;
  assign alu_op[alu_slt]  = is_slt | is_slti;
  assign alu_op[alu_sltu] = is_sltu | is_sltui;
  assign alu_op[alu_and]  = is_and | is_andi;
  assign alu_op[alu_nor]  = is_nor;
  assign alu_op[alu_or]   = is_or | is_ori;
  assign alu_op[alu_xor]  = is_xor | is_xori;
  assign alu_op[alu_sll]  = is_sll | is_slli;
  assign alu_op[alu_srl]  = is_srl | is_srli;
  assign alu_op[alu_sra]  = is_sra | is_srai;
  assign alu_op[alu_lui]  = is_lu12i;

  assign reg_3r = is_add | is_sub | is_slt | is_sltu | is_and | is_or | is_nor | is_xor |
                  is_sll | is_srl | is_sra;

  assign need_ui5  = is_slli | is_srli | is_srai;
  assign need_si12 = is_addi | is_slti | is_sltui;
  assign need_ui12 = is_andi | is_ori | is_xori;
  assign need_si16 = is_cond_br | is_jirl;
  assign need_i20  = is_lu12i | is_pcaddu12i;
  assign need_si26 = is_b | is_bl;

  always_comb begin
    imm = '0;
    if (need_ui5) begin
      imm = {27'b0, inst.fmt_3r.rk};
    end else if (need_si12) begin
      imm = {{20{inst.fmt_2ri12.i12[11]}}, inst.fmt_2ri12.i12};
    end else if (need_ui12) begin
      imm = {20'b0, inst.fmt_2ri12.i12};
    end else if (need_si16) begin
      imm = {{14{inst.fmt_2ri16.i16[15]}}, inst.fmt_2ri16.i16, 2'b0};
    end else if (need_i20) begin
      imm = {inst.fmt_1ri20.i20, 12'b0};
    end else if (need_si26) begin
      imm = {{4{inst.fmt_i26.i26_hi[9]}}, inst.fmt_i26.i26_hi, inst.fmt_i26.i26_lo, 2'b0};
    end
  end

  assign src1_is_pc  = is_jirl | is_bl | is_pcaddu12i;
  assign src2_is_imm = need_ui5 | need_si12 | need_ui12 | need_i20;
  assign src2_is_4   = is_jirl | is_bl;
  assign gr_we       = !(is_cond_br || is_b);

  assign need_rj  = reg_3r | need_ui5 | need_si12 | need_ui12 | is_cond_br | is_jirl;
  assign need_rkd = reg_3r | is_cond_br;

  // conditional branches compare rj against rd
  assign raddr1 = inst.fmt_3r.rj;
  assign raddr2 = is_cond_br ? inst.fmt_2ri16.rd : inst.fmt_3r.rk;
  assign dest   = is_bl ? reg_addr_w'(1) : inst.fmt_3r.rd;

endmodule

`default_nettype wire

//--- operand_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module operand_bypass (
  input  logic [decode_pkg::reg_addr_w-1:0] raddr1,
  input  logic [decode_pkg::reg_addr_w-1:0] raddr2,
  input  logic                              need_rj,
  input  logic                              need_rkd,
  input  logic [decode_pkg::xlen-1:0]       rdata1,
  input  logic [decode_pkg::xlen-1:0]       rdata2,
  input  decode_pkg::fwd_t                  es_fwd,
  input  decode_pkg::fwd_t                  ms_fwd,
  input  decode_pkg::wb_t                   wb,
  output logic [decode_pkg::xlen-1:0]       rj_value,
  output logic [decode_pkg::xlen-1:0]       rkd_value,
  output logic                              stall
);
  import decode_pkg::*;

  logic stall_rj;
  logic stall_rkd;

  // returns {not_ready, value} of the youngest producer of addr
  function automatic logic [xlen:0] pick_src(
    input logic [reg_addr_w-1:0] addr,
    input logic                  need,
    input logic [xlen-1:0]       rf_data,
    input fwd_t                  es,
    input fwd_t                  ms,
    input wb_t                   w
  );
    logic used;
    used = need && (addr != '0);
    if (used && es.valid && es.dest == addr) begin
      return {es.not_ready, es.data};
    end
    if (used && ms.valid && ms.dest == addr) begin
      return {ms.not_ready, ms.data};
    end
    if (used && w.we && w.waddr == addr) begin
      return {1'b0, w.wdata};
    end
    return {1'b0, rf_data};
  endfunction

  assign {stall_rj, rj_value}   = pick_src(raddr1, need_rj, rdata1, es_fwd, ms_fwd, wb);
  assign {stall_rkd, rkd_value} = pick_src(raddr2, need_rkd, rdata2, es_fwd, ms_fwd, wb);

  assign stall = stall_rj | stall_rkd;

endmodule

`default_nettype wire

//--- tb_id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage;
  import decode_pkg::*;

  localparam int test_cycles = 2000;
  // random phase plus half again for register fill and drain
  localparam int max_cycles  = test_cycles + test_cycles / 2;

  logic      clk;
  logic      rst_n;
  logic      fs_valid;
  fs_to_ds_t fs_bus;
  logic      ds_allowin;
  logic      ds_to_es_valid;
  ds_to_es_t ds_to_es_bus;
  logic      es_allowin;
  br_bus_t   br_bus;
  fwd_t      es_fwd;
  fwd_t      ms_fwd;
  wb_t       ws;
  int        error_count;
  int        check_count;
  int        cycles = 0;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  id_stage i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .fs_valid       (fs_valid),
    .fs_bus         (fs_bus),
    .ds_allowin     (ds_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es_bus   (ds_to_es_bus),
    .es_allowin     (es_allowin),
    .br_bus         (br_bus),
    .es_fwd         (es_fwd),
    .ms_fwd         (ms_fwd),
    .ws             (ws)
  );

  id_checker i_check (
    .clk            (clk),
    .rst_n          (rst_n),
    .fs_valid       (fs_valid),
    .fs_bus         (fs_bus),
    .ds_allowin     (ds_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es_bus   (ds_to_es_bus),
    .es_allowin     (es_allowin),
    .br_bus         (br_bus),
    .es_fwd         (es_fwd),
    .ms_fwd         (ms_fwd),
    .ws             (ws),
    .error_count    (error_count),
    .check_count    (check_count)
  );

  // mostly low registers so producers collide often
  function automatic logic [4:0] pick_reg();
    if ($urandom_range(0, 3) != 0) return 5'($urandom_range(0, 7));
    return 5'($urandom_range(0, 31));
  endfunction

  function automatic logic [31:0] make_inst();
    logic [4:0]  rd, rj, rk;
    logic [31:0] rnd;
    logic [16:0] op17;
    logic [9:0]  op10;
    logic [5:0]  op6;
    int          k;
    rd = pick_reg();
    rj = pick_reg();
    rk = pick_reg();
    rnd = $urandom;
    k = $urandom_range(0, 30);
    op17 = op_add_w;
    op10 = op_addi_w;
    if (k < 14) begin
      case (k)
        1:  op17 = op_sub_w;
        2:  op17 = op_slt;
        3:  op17 = op_sltu;
        4:  op17 = op_nor;
        5:  op17 = op_and;
        6:  op17 = op_or;
        7:  op17 = op_xor;
        8:  op17 = op_sll_w;
        9:  op17 = op_srl_w;
        10: op17 = op_sra_w;
        11: op17 = op_slli_w;
        12: op17 = op_srli_w;
        13: op17 = op_srai_w;
        default: ;
      endcase
      return {op17, rk, rj, rd};
    end else if (k < 20) begin
      case (k)
        15: op10 = op_slti;
        16: op10 = op_sltui;
        17: op10 = op_andi;
        18: op10 = op_ori;
        19: op10 = op_xori;
        default: ;
      endcase
      return {op10, rnd[11:0], rj, rd};
    end else if (k < 22) begin
      return {(k == 20) ? op_lu12i_w : op_pcaddu12i, rnd[19:0], rd};
    end
    // branch opcodes are contiguous from jirl to bgeu
    op6 = op_jirl + 6'(k - 22);
    if (op6 == op_b || op6 == op_bl) return {op6, rnd[25:0]};
    return {op6, rnd[15:0], rj, rd};
  endfunction

  function automatic fwd_t random_fwd();
    fwd_t f;
    f.valid     = $urandom_range(0, 1);
    f.not_ready = ($urandom_range(0, 7) == 0);
    f.dest      = pick_reg();
    f.data      = $urandom;
    return f;
  endfunction

  task automatic drive_random();
    fs_valid    = ($urandom_range(0, 3) != 0);
    fs_bus.pc   = $urandom & 32'hffff_fffc;
    fs_bus.inst = make_inst();
    es_allowin  = ($urandom_range(0, 3) != 0);
    es_fwd      = random_fwd();
    ms_fwd      = random_fwd();
    ws.we       = $urandom_range(0, 1);
    ws.waddr    = pick_reg();
    ws.wdata    = $urandom;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, the stage did not drain", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h94ae_ad9f));
    rst_n      = 1'b0;
    fs_valid   = 1'b0;
    fs_bus     = '0;
    es_allowin = 1'b0;
    es_fwd     = '0;
    ms_fwd     = '0;
    ws         = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // fill the register file so every read is defined
    for (int a = 1; a < nregs; a++) begin
      ws = '{we: 1'b1, waddr: 5'(a), wdata: $urandom};
      @(negedge clk);
    end

    for (int n = 0; n < test_cycles; n++) begin
      drive_random();
      @(negedge clk);
    end

    fs_valid         = 1'b0;
    es_allowin       = 1'b1;
    es_fwd.not_ready = 1'b0;
    ms_fwd.not_ready = 1'b0;
    ws.we            = 1'b0;
    @(negedge clk);
    while (!ds_allowin) @(negedge clk);
    @(negedge clk);

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
